// File: hw/div_settings.svh
`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

`define DIV_W     32
`define DIV_ITER  16
`define DIV_CNT_W 4

`endif

// File: hw/div_pkg.sv
`include "div_settings.svh"

package div_pkg;

	typedef enum logic [1:0]
	{
		S_IDLE = 2'd0,
		S_ITER = 2'd1,
		S_DONE = 2'd2
	} div_state_e;

	typedef struct packed
	{
		logic [`DIV_W-1:0] dividend;  // magnitude once captured
		logic [`DIV_W-1:0] divisor;
		logic              uns;
		logic              neg_dvd;   // remainder takes this sign
		logic              neg_quot;
	} div_opnd_t;

endpackage

// File: hw/div_step_if.sv
`timescale 1ns/1ps
`include "div_settings.svh"

interface div_step_if
	import div_pkg::*;
();

	logic              load;         // one cycle, start accepted
	logic              step;         // high while digits shift in
	div_opnd_t         opnd;
	logic [`DIV_W:0]   dvs_add;      // divisor, inverted when subtracting
	logic              sub;
	logic [1:0]        digit;
	logic [`DIV_W-1:0] urem_final;
	logic [`DIV_W-1:0] uquot_final;

	modport ctrl (output load, output step);

	modport prep (input load, output opnd, output dvs_add, output sub);

	modport stage (input load, input step, input opnd, input dvs_add, input sub,
		output digit, output urem_final, output uquot_final);

	modport fix (input opnd, input urem_final, input uquot_final);

endinterface

// File: hw/div_ctrl.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module div_ctrl
	import div_pkg::*;
(
	input  logic     clk,
	input  logic     rstn,
	input  logic     en,
	output logic     fin,
	div_step_if.ctrl bus
);

	localparam logic [`DIV_CNT_W-1:0] LAST_CNT = `DIV_CNT_W'(`DIV_ITER - 1);

	div_state_e            state;
	logic [`DIV_CNT_W-1:0] cnt;
	logic                  accept;
	logic                  last;

	assign accept = en && ((state == S_IDLE) || (state == S_DONE));
	assign last   = (state == S_ITER) && (cnt == LAST_CNT);  // wait cycle for final digit

	assign bus.load = accept;
	assign bus.step = (state == S_ITER) && !last;

	always_ff @(posedge clk)
	begin
		if (!rstn)
		begin
			state <= S_IDLE;
			cnt   <= '0;
			fin   <= 1'b0;
		end
		else
		begin
			case (state)
				S_IDLE, S_DONE:
				begin
					if (accept)
					begin
						state <= S_ITER;
						cnt   <= '0;
						fin   <= 1'b0;
					end
				end
				S_ITER:
				begin
					cnt <= cnt + 1'b1;
					if (last)
					begin
						state <= S_DONE;
						fin   <= 1'b1;  // held until next accept
					end
				end
				default:
				begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	a_load_then_step: assert property (@(posedge clk) disable iff (!rstn)
		bus.load |=> (bus.step && !fin))
		else $error("no first step after a start, state %s", state.name());

	a_fin_fall: assert property (@(posedge clk) disable iff (!rstn)
		$fell(fin) |-> $past(bus.load))
		else $error("fin dropped without a start, state %s", state.name());

endmodule

// File: hw/div_operand_prep.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module div_operand_prep
	import div_pkg::*;
(
	input  logic              clk,
	input  logic              rstn,
	input  logic              uns,
	input  logic [`DIV_W-1:0] dividend,
	input  logic [`DIV_W-1:0] divisor,
	div_step_if.prep          bus
);

	localparam int W = `DIV_W;

	div_opnd_t      opnd_q;
	div_opnd_t      opnd_d;
	logic           dvd_neg;
	logic [W-1:0]   dvd_mag;

	assign dvd_neg = ~uns & dividend[W-1];
	assign dvd_mag = ({W{dvd_neg}} ^ dividend) + W'(dvd_neg);  // -2^31 stays 2^31 unsigned

	always_comb
	begin
		opnd_d.dividend = dvd_mag;
		opnd_d.divisor  = divisor;
		opnd_d.uns      = uns;
		opnd_d.neg_dvd  = dvd_neg;
		opnd_d.neg_quot = ~uns & (dividend[W-1] ^ divisor[W-1]);
	end

	always_ff @(posedge clk)
	begin
		if (!rstn)
		begin
			opnd_q.uns      <= 1'b1;
			opnd_q.neg_dvd  <= 1'b0;
			opnd_q.neg_quot <= 1'b0;
		end
		else if (bus.load)
		begin
			opnd_q <= opnd_d;
		end
	end

	// the stage loads its register on the same edge, so it sees the fresh magnitude
	always_comb
	begin
		bus.opnd = opnd_q;
		if (bus.load)
			bus.opnd.dividend = dvd_mag;
	end

	assign bus.sub     = ~opnd_q.divisor[W-1] | opnd_q.uns;  // negative divisor is added
	assign bus.dvs_add = {(W+1){bus.sub}}
		^ {~opnd_q.uns & opnd_q.divisor[W-1], opnd_q.divisor};

endmodule

// File: hw/div_radix4_stage.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module div_radix4_stage
	import div_pkg::*;
(
	input  logic      clk,
	input  logic      rstn,
	div_step_if.stage bus
);

	localparam int W = `DIV_W;

	logic [2*W-1:0] acc;        // partial remainder over dividend/quotient bits
	logic [W-1:0]   part_rem;
	logic [W:0]     rem1;
	logic [W+1:0]   rem2;
	logic [W+2:0]   rem3;
	logic [W+2:0]   csa_a;
	logic [W+2:0]   csa_b;
	logic [W+2:0]   csa_c;
	logic [W+2:0]   csa_s;
	logic [W+2:0]   csa_cy;
	logic [1:0]     digit;
	logic [W-1:0]   sel_rem;

	assign part_rem = acc[2*W-1:W];

	// R + 3D as R + D + 2D, signed divisor word sign extended
	assign csa_a = {3'b000, part_rem};
	assign csa_b = {{2{bus.dvs_add[W]}}, bus.dvs_add};
	assign csa_c = {bus.dvs_add[W], bus.dvs_add, bus.sub};

	always_comb
	begin
		for (int i = 0; i < W + 3; i++)
		begin
			csa_s[i]  = csa_a[i] ^ csa_b[i] ^ csa_c[i];
			csa_cy[i] = (csa_a[i] & csa_b[i]) | (csa_a[i] & csa_c[i])
				| (csa_b[i] & csa_c[i]);
		end
	end

	// each sub term carries its own +1 for the two's complement
	assign rem1 = {1'b0, part_rem} + bus.dvs_add + {{W{1'b0}}, bus.sub};
	assign rem2 = {2'b00, part_rem} + {bus.dvs_add, bus.sub} + {{(W+1){1'b0}}, bus.sub};
	assign rem3 = csa_s + {csa_cy[W+1:0], bus.sub} + {{(W+2){1'b0}}, bus.sub};

	// sign bits fall 1,2,3 times D in turn
	assign digit = {~rem2[W+1], ~(rem1[W] ^ rem2[W+1] ^ rem3[W+2])};

	always_comb
	begin
		case (digit)
			2'd0:    sel_rem = part_rem;
			2'd1:    sel_rem = rem1[W-1:0];
			2'd2:    sel_rem = rem2[W-1:0];
			default: sel_rem = rem3[W-1:0];
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rstn)
		begin
			acc <= '0;
		end
		else if (bus.load)
		begin
			acc <= {{(W-2){1'b0}}, bus.opnd.dividend, 2'b00};
		end
		else if (bus.step)
		begin
			// remainder below 2^30 here, top bits drop safely
			acc <= {sel_rem[W-3:0], acc[W-1:0], digit};
		end
	end

	assign bus.digit       = digit;
	assign bus.uquot_final = {acc[W-3:0], digit};  // 16th digit never registered
	assign bus.urem_final  = sel_rem;

	a_digit_known: assert property (@(posedge clk) disable iff (!rstn)
		bus.step |-> !$isunknown(bus.digit))
		else $error("digit unknown during iteration");

endmodule

// File: hw/div_result_fix.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module div_result_fix
	import div_pkg::*;
(
	output logic [`DIV_W-1:0] quot,
	output logic [`DIV_W-1:0] rem,
	div_step_if.fix           bus
);

	localparam int W = `DIV_W;

	logic neg_q;
	logic neg_r;

	// unsigned mode leaves both untouched
	assign neg_q = bus.opnd.neg_quot & ~bus.opnd.uns;
	assign neg_r = bus.opnd.neg_dvd & ~bus.opnd.uns;

	assign quot = ({W{neg_q}} ^ bus.uquot_final) + W'(neg_q);  // truncation toward zero
	assign rem  = ({W{neg_r}} ^ bus.urem_final) + W'(neg_r);   // sign follows dividend

endmodule

// File: hw/div_top.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module div_top
(
	input  logic              clk,
	input  logic              rstn,
	input  logic              en,
	input  logic              uns,
	input  logic [`DIV_W-1:0] dividend,
	input  logic [`DIV_W-1:0] divisor,
	output logic [`DIV_W-1:0] quot,
	output logic [`DIV_W-1:0] rem,
	output logic              fin
);

	div_step_if bus ();

	div_ctrl i_ctrl
	(
		.clk  (clk),
		.rstn (rstn),
		.en   (en),
		.fin  (fin),
		.bus  (bus.ctrl)
	);

	div_operand_prep i_prep
	(
		.clk      (clk),
		.rstn     (rstn),
		.uns      (uns),
		.dividend (dividend),
		.divisor  (divisor),
		.bus      (bus.prep)
	);

	div_radix4_stage i_stage
	(
		.clk  (clk),
		.rstn (rstn),
		.bus  (bus.stage)
	);

	div_result_fix i_fix
	(
		.quot (quot),
		.rem  (rem),
		.bus  (bus.fix)
	);

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen
(
	output logic clk,
	output logic rstn
);

	initial
	begin
		clk  = 1'b0;
		rstn = 1'b0;
		repeat (3) @(posedge clk);
		rstn <= 1'b1;  // released after three edges
	end

	always #2 clk = ~clk;  // 4 ns period

endmodule

// File: tb/tb_div.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module tb_div;

	localparam int W        = `DIV_W;
	localparam int N_VEC    = 16;
	localparam int N_RAND   = 200;
	localparam int MAX_CYC  = (N_VEC + N_RAND) * 20 + 100;
	localparam int FIN_WAIT = 2 * `DIV_ITER + 8;

	typedef struct packed
	{
		logic         uns;
		logic [W-1:0] dvd;
		logic [W-1:0] dvs;
		logic [W-1:0] q;
		logic [W-1:0] r;
	} vec_t;

	localparam vec_t VECS [N_VEC] = '{
		'{1'b1, 32'd100,        32'd7,        32'd14,       32'd2},
		'{1'b1, 32'hDEADBEEF,   32'd1,        32'hDEADBEEF, 32'd0},
		'{1'b1, 32'd5,          32'd9,        32'd0,        32'd5},
		'{1'b1, 32'hFFFFFFFF,   32'd3,        32'h55555555, 32'd0},
		'{1'b1, 32'hFFFFFFFF,   32'hFFFFFFFF, 32'd1,        32'd0},
		'{1'b1, 32'h80000000,   32'd7,        32'h12492492, 32'd2},
		'{1'b1, 32'hFFFFFFFF,   32'd2,        32'h7FFFFFFF, 32'd1},
		'{1'b1, 32'd0,          32'd5,        32'd0,        32'd0},
		'{1'b0, 32'hFFFFFFF9,   32'd2,        32'hFFFFFFFD, 32'hFFFFFFFF},  // -7 / 2
		'{1'b0, 32'd7,          32'hFFFFFFFE, 32'hFFFFFFFD, 32'd1},
		'{1'b0, 32'hFFFFFFF9,   32'hFFFFFFFE, 32'd3,        32'hFFFFFFFF},
		'{1'b0, 32'd7,          32'd2,        32'd3,        32'd1},
		'{1'b0, 32'h80000000,   32'd1,        32'h80000000, 32'd0},
		'{1'b0, 32'hFFFFFF9C,   32'd7,        32'hFFFFFFF2, 32'hFFFFFFFE},  // -100 / 7
		'{1'b0, 32'd100,        32'hFFFFFFF9, 32'hFFFFFFF2, 32'd2},
		'{1'b0, 32'h7FFFFFFF,   32'h80000000, 32'd0,        32'h7FFFFFFF}
	};

	logic         clk;
	logic         rstn;
	logic         en;
	logic         uns;
	logic [W-1:0] dividend;
	logic [W-1:0] divisor;
	logic [W-1:0] quot;
	logic [W-1:0] rem;
	logic         fin;

	int           val_err  = 0;
	int           time_err = 0;
	int           cyc      = 0;
	logic [31:0]  rng      = 32'd49;

	tb_clk_gen i_clk (.clk(clk), .rstn(rstn));

	div_top i_dut
	(
		.clk      (clk),
		.rstn     (rstn),
		.en       (en),
		.uns      (uns),
		.dividend (dividend),
		.divisor  (divisor),
		.quot     (quot),
		.rem      (rem),
		.fin      (fin)
	);

	task automatic check_word(input string name, input logic [W-1:0] exp,
		input logic [W-1:0] act);
		if (act !== exp)
		begin
			val_err++;
			$display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			val_err++;
			$display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// truncating division, remainder = dividend - quotient * divisor
	task automatic ref_div(input logic u, input logic [W-1:0] a, input logic [W-1:0] b,
		output logic [W-1:0] q, output logic [W-1:0] r);
		logic signed [W-1:0] sa;
		logic signed [W-1:0] sb;
		sa = a;
		sb = b;
		if (u)
			q = a / b;
		else
			q = sa / sb;
		r = a - q * b;
	endtask

	// start one division, return at the negedge where fin is seen
	task automatic run_div(input logic u, input logic [W-1:0] a, input logic [W-1:0] b,
		input int busy_at, output logic ok);
		int   n;
		logic seen;
		n    = 0;
		seen = 1'b0;
		@(posedge clk);
		en       <= 1'b1;
		uns      <= u;
		dividend <= a;
		divisor  <= b;
		@(posedge clk);  // edge 0, start accepted
		en <= 1'b0;
		while (!seen && n < FIN_WAIT)
		begin
			@(posedge clk);
			n++;
			if (n == busy_at)
			begin
				en       <= 1'b1;  // must be ignored while busy
				uns      <= ~u;
				dividend <= ~a;
				divisor  <= 32'd3;
			end
			else
				en <= 1'b0;
			@(negedge clk);
			seen = fin;
		end
		if (!seen)
		begin
			time_err++;
			$display("fin never rose within %0d cycles of the start", FIN_WAIT);
		end
		else if (n != `DIV_ITER)
		begin
			time_err++;
			$display("fin rose %0d cycles after the start, expected %0d", n, `DIV_ITER);
		end
		ok = seen;
	endtask

	task automatic apply_case(input logic u, input logic [W-1:0] a, input logic [W-1:0] b,
		input logic [W-1:0] eq, input logic [W-1:0] er, input int busy_at);
		logic ok;
		run_div(u, a, b, busy_at, ok);
		if (ok)
		begin
			check_word("quot", eq, quot);
			check_word("rem", er, rem);
		end
	endtask

	task automatic hold_check(input logic [W-1:0] eq, input logic [W-1:0] er);
		repeat (5)
		begin
			@(posedge clk);
			@(negedge clk);
			check_word("quot", eq, quot);
			check_word("rem", er, rem);
			check_bit("fin", 1'b1, fin);
		end
	endtask

	always @(posedge clk)
	begin
		cyc++;
		if (cyc >= MAX_CYC)
		begin
			$display("timeout, run stopped after %0d cycles", cyc);
			$display("test failed");
			$finish;
		end
	end

	initial
	begin
		logic         u;
		logic [W-1:0] a;
		logic [W-1:0] b;
		logic [W-1:0] eq;
		logic [W-1:0] er;
		logic [4:0]   sh;
		en       = 1'b0;
		uns      = 1'b0;
		dividend = '0;
		divisor  = 32'd1;
		wait (rstn === 1'b1);
		repeat (4)
		begin
			@(negedge clk);
			check_bit("fin", 1'b0, fin);  // idle out of reset
		end

		for (int i = 0; i < N_VEC; i++)
		begin
			apply_case(VECS[i].uns, VECS[i].dvd, VECS[i].dvs, VECS[i].q, VECS[i].r,
				(i % 4 == 3) ? 5 : 0);
			hold_check(VECS[i].q, VECS[i].r);
		end

		for (int i = 0; i < N_RAND; i++)
		begin
			rng = xorshift(rng);
			u   = rng[0];
			rng = xorshift(rng);
			a   = rng;
			do
			begin
				rng = xorshift(rng);
				sh  = rng[4:0];
				rng = xorshift(rng);
				b   = rng >> sh;  // spread of divisor sizes
			end
			while (b == '0 || (!u && a == 32'h80000000 && b == 32'hFFFFFFFF));
			ref_div(u, a, b, eq, er);
			apply_case(u, a, b, eq, er, 0);
		end

		$display("errors %0d value, %0d timing", val_err, time_err);
		if (val_err == 0 && time_err == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+hw
hw/div_pkg.sv
hw/div_step_if.sv
hw/div_ctrl.sv
hw/div_operand_prep.sv
hw/div_radix4_stage.sv
hw/div_result_fix.sv
hw/div_top.sv
tb/tb_clk_gen.sv
tb/tb_div.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_div \
	-Mdir "$BUILD_DIR" -o sim_div
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

"./$BUILD_DIR/sim_div" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "test passed" "$LOG_FILE"; then
	exit 0
fi
exit 1
